// File: dv/dcache_assertions.sv
`timescale 1ns/100ps
`default_nettype none

module dcache_assertions
    import dcache_pkg::*;
(
    input  wire             clk,
    input  wire             rstn,
    input  wire             i_ready,
    input  wire dc_resp_t   i_resp,
    input  wire mem_rreq_t  i_rreq,
    input  wire             i_rready,
    input  wire mem_wreq_t  i_wreq,
    input  wire             i_wready
);

    int err_cnt = 0;   // number of failed properties

    idle_after_reset: assert property (@(posedge clk)
        !rstn |=> !i_ready && !i_rreq.valid && !i_wreq.valid)
    else begin
        $error("outputs not idle after reset");
        err_cnt++;
    end

    // read request held until the handshake
    rreq_hold: assert property (@(posedge clk) disable iff (!rstn)
        i_rreq.valid && !i_rready |=> i_rreq.valid && $stable(i_rreq.addr))
    else begin
        $error("memory read request changed before its handshake");
        err_cnt++;
    end

    wreq_hold: assert property (@(posedge clk) disable iff (!rstn)
        i_wreq.valid && !i_wready |=>
            i_wreq.valid && $stable(i_wreq.addr) && $stable(i_wreq.data))
    else begin
        $error("memory write request changed before its handshake");
        err_cnt++;
    end

    ready_pulse: assert property (@(posedge clk) disable iff (!rstn)
        i_ready |=> !i_ready)
    else begin
        $error("ready high for two cycles in a row");
        err_cnt++;
    end

    // exception gives zero data and starts no memory traffic
    excp_quiet: assert property (@(posedge clk) disable iff (!rstn)
        i_ready && i_resp.excp |->
            i_resp.rdata == 32'd0 ##1 (!i_rreq.valid && !i_wreq.valid))
    else begin
        $error("exception response with data or memory traffic");
        err_cnt++;
    end

endmodule

`default_nettype wire

// File: dv/dcache_tb.sv
`timescale 1ns/100ps
`default_nettype none

`include "dcache_macros.svh"

module dcache_tb
    import dcache_pkg::*;
();

    localparam int MEM_BYTES      = 16384;   // 4 tags per set, plenty of evictions
    localparam int NUM_LOADS      = 40;
    localparam int NUM_MIXED      = 80;
    localparam int NUM_DIRECTED   = 24;
    localparam int CYCLES_PER_REQ = 24;      // miss with both ports at max delay, plus margin
    localparam int TIMEOUT_CYCLES =
        (NUM_LOADS + NUM_MIXED + NUM_DIRECTED) * CYCLES_PER_REQ + 100;

    logic        clk;
    logic        rstn;
    logic        i_req_valid;
    dc_req_t     i_req;
    logic        o_ready;
    dc_resp_t    o_resp;
    mem_rreq_t   o_mem_rreq;
    logic        i_mem_rready;
    line_t       i_mem_rdata;
    mem_wreq_t   o_mem_wreq;
    logic        i_mem_wready;

    logic [7:0]  mem    [MEM_BYTES];   // backing memory
    logic [7:0]  shadow [MEM_BYTES];   // what the pipeline should see
    int          seed = 32'hcebd;
    int          cycle_cnt;
    dc_resp_t    resp;
    int          lat;
    logic        saw_traffic;

    dcache_top UUT (
        .clk          (clk),
        .rstn         (rstn),
        .i_req_valid  (i_req_valid),
        .i_req        (i_req),
        .o_ready      (o_ready),
        .o_resp       (o_resp),
        .o_mem_rreq   (o_mem_rreq),
        .i_mem_rready (i_mem_rready),
        .i_mem_rdata  (i_mem_rdata),
        .o_mem_wreq   (o_mem_wreq),
        .i_mem_wready (i_mem_wready)
    );

    bind dcache_top dcache_assertions u_asserts (
        .clk      (clk),
        .rstn     (rstn),
        .i_ready  (o_ready),
        .i_resp   (o_resp),
        .i_rreq   (o_mem_rreq),
        .i_rready (i_mem_rready),
        .i_wreq   (o_mem_wreq),
        .i_wready (i_mem_wready)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic stop_run(input string msg);
        $display("%s", msg);
        $display("CHECKS FAILED");
        $fatal(1, "run aborted");
    endtask

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else
            stop_run($sformatf("[ERROR] %0t: %s is %h, expected %h", $time, what, got, exp));
    endtask

    function automatic line_t line_of(input logic from_shadow, input logic [31:0] addr);
        line_t l;
        int    base;
        base = addr & 32'h3fc0;
        for (int i = 0; i < 64; i++) begin
            l[i*8 +: 8] = from_shadow ? shadow[base + i] : mem[base + i];
        end
        return l;
    endfunction

    function automatic logic [3:0] strobes(input logic [31:0] addr, input logic [1:0] size);
        case (size)
            `DC_SIZE_BYTE: return 4'b0001 << addr[1:0];
            `DC_SIZE_HALF: return 4'b0011 << addr[1:0];
            default:       return 4'b1111;
        endcase
    endfunction

    // little endian lanes, sign taken from the top loaded byte
    function automatic logic [31:0] expected_load(input logic [31:0] addr,
                                                  input logic [1:0] size, input logic sign_ext);
        logic [31:0] v;
        int          a;
        a = addr & 32'h3fff;
        case (size)
            `DC_SIZE_BYTE: begin
                v = {24'd0, shadow[a]};
                if (sign_ext && v[7]) v[31:8] = '1;
            end
            `DC_SIZE_HALF: begin
                v = {16'd0, shadow[a + 1], shadow[a]};
                if (sign_ext && v[15]) v[31:16] = '1;
            end
            default: v = {shadow[a + 3], shadow[a + 2], shadow[a + 1], shadow[a]};
        endcase
        return v;
    endfunction

    task automatic access(input logic [31:0] addr, input logic [1:0] size, input logic write,
                          input logic sign_ext, input logic [31:0] wdata);
        @(negedge clk);
        i_req_valid    = 1'b1;
        i_req.addr     = addr;
        i_req.wdata    = wdata;
        i_req.strb     = strobes(addr, size);
        i_req.size     = size;
        i_req.write    = write;
        i_req.sign_ext = sign_ext;
        lat            = 0;
        saw_traffic    = 1'b0;
        do begin
            @(negedge clk);
            lat++;
            if (o_mem_rreq.valid || o_mem_wreq.valid) saw_traffic = 1'b1;
        end while (!o_ready);
        resp        = o_resp;
        i_req_valid = 1'b0;
    endtask

    task automatic load_check(input logic [31:0] addr, input logic [1:0] size,
                              input logic sign_ext);
        access(addr, size, 1'b0, sign_ext, 32'd0);
        check_value("load exception flag", resp.excp, 1'b0);
        check_value($sformatf("load data at %h", addr), resp.rdata,
                    expected_load(addr, size, sign_ext));
    endtask

    task automatic store_apply(input logic [31:0] addr, input logic [1:0] size,
                               input logic [31:0] wdata);
        logic [3:0] strb;
        strb = strobes(addr, size);
        access(addr, size, 1'b1, 1'b0, wdata);
        check_value("store exception flag", resp.excp, 1'b0);
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) shadow[(addr & 32'h3ffc) + b] = wdata[b*8 +: 8];
        end
    endtask

    task automatic misaligned_check(input logic [31:0] addr, input logic [1:0] size,
                                    input logic write);
        access(addr, size, write, 1'b1, 32'hdead_beef);
        @(negedge clk);   // a wrongly started miss shows up here
        if (o_mem_rreq.valid || o_mem_wreq.valid) saw_traffic = 1'b1;
        check_value("exception flag", resp.excp, 1'b1);
        check_value("exception read data", resp.rdata, 32'd0);
        check_value("exception latency", lat, 1);
        check_value("memory traffic on exception", saw_traffic, 1'b0);
    endtask

    task automatic random_traffic(input int count, input logic with_stores);
        logic [31:0] r;
        logic [31:0] addr;
        logic [1:0]  size;
        for (int n = 0; n < count; n++) begin
            r    = $random(seed);
            size = (r[1:0] == 2'b11) ? `DC_SIZE_WORD : r[1:0];
            addr = $random(seed) & 32'h3fff;
            if (size == `DC_SIZE_HALF) addr[0] = 1'b0;
            if (size == `DC_SIZE_WORD) addr[1:0] = 2'b00;
            if (with_stores && r[2]) begin
                store_apply(addr, size, $random(seed));
            end else begin
                load_check(addr, size, r[3]);
            end
        end
    endtask

    initial begin : read_port
        int delay;
        forever begin
            @(negedge clk);
            if (o_mem_rreq.valid) begin
                delay = $unsigned($random(seed)) % 8;
                repeat (delay) @(negedge clk);
                i_mem_rdata  = line_of(1'b0, o_mem_rreq.addr);
                i_mem_rready = 1'b1;
                @(negedge clk);
                i_mem_rready = 1'b0;
            end
        end
    end

    initial begin : write_port
        int delay;
        int base;
        forever begin
            @(negedge clk);
            if (o_mem_wreq.valid) begin
                delay = $unsigned($random(seed)) % 8;
                repeat (delay) @(negedge clk);
                assert (o_mem_wreq.data === line_of(1'b1, o_mem_wreq.addr)) else
                    stop_run($sformatf("[ERROR] %0t: write-back of line %h has stale data",
                                       $time, o_mem_wreq.addr));
                base = o_mem_wreq.addr & 32'h3fc0;
                for (int i = 0; i < 64; i++) begin
                    mem[base + i] = o_mem_wreq.data[i*8 +: 8];
                end
                i_mem_wready = 1'b1;
                @(negedge clk);
                i_mem_wready = 1'b0;
            end
        end
    end

    initial begin : watchdog
        cycle_cnt = 0;
        forever begin
            @(negedge clk);
            cycle_cnt++;
            if (UUT.u_asserts.err_cnt != 0) stop_run("a protocol assertion on the cache failed");
            if (cycle_cnt >= TIMEOUT_CYCLES) stop_run("timeout, the cache stopped responding");
        end
    end

    initial begin : stimulus
        logic [31:0] x;
        logic [31:0] a;
        rstn         = 1'b0;
        i_req_valid  = 1'b0;
        i_req        = '0;
        i_mem_rready = 1'b0;
        i_mem_rdata  = '0;
        i_mem_wready = 1'b0;
        for (int i = 0; i < MEM_BYTES; i++) begin
            mem[i]    = $random(seed);
            shadow[i] = mem[i];
        end
        repeat (5) @(negedge clk);
        rstn = 1'b1;

        random_traffic(NUM_LOADS, 1'b0);

        // three dirty lines in set 5, later misses evict dirty victims
        x = 32'h0000_0140;
        store_apply(x + 4, `DC_SIZE_WORD, 32'h1122_3344);
        store_apply(x + 9, `DC_SIZE_BYTE, 32'h0000_9a00);
        store_apply(x + 32'h1002, `DC_SIZE_HALF, 32'hf00d_0000);
        store_apply(x + 32'h203c, `DC_SIZE_WORD, 32'hcafe_f00d);
        load_check(x + 4, `DC_SIZE_WORD, 1'b0);
        load_check(x + 9, `DC_SIZE_BYTE, 1'b1);
        load_check(x + 32'h1002, `DC_SIZE_HALF, 1'b1);
        load_check(x + 32'h203c, `DC_SIZE_WORD, 1'b0);

        // A, B, A, then C evicts B and A still hits
        a = 32'h0000_0244;
        load_check(a, `DC_SIZE_WORD, 1'b0);
        load_check(a + 32'h1000, `DC_SIZE_WORD, 1'b0);
        load_check(a, `DC_SIZE_WORD, 1'b0);
        check_value("hit latency", lat, 1);
        check_value("memory traffic on hit", saw_traffic, 1'b0);
        load_check(a + 32'h2000, `DC_SIZE_WORD, 1'b0);
        load_check(a, `DC_SIZE_HALF, 1'b1);
        check_value("hit latency after eviction", lat, 1);
        check_value("memory traffic on hit after eviction", saw_traffic, 1'b0);
        load_check(a + 32'h1000, `DC_SIZE_WORD, 1'b0);
        check_value("refetch of evicted line", saw_traffic, 1'b1);

        misaligned_check(32'h0000_0341, `DC_SIZE_HALF, 1'b0);
        misaligned_check(32'h0000_0382, `DC_SIZE_WORD, 1'b1);
        load_check(32'h0000_0380, `DC_SIZE_WORD, 1'b0);   // store above left no trace
        misaligned_check(32'h0000_0003, `DC_SIZE_HALF, 1'b1);
        load_check(32'h0000_0000, `DC_SIZE_WORD, 1'b0);

        random_traffic(NUM_MIXED, 1'b1);

        repeat (4) @(negedge clk);
        if (UUT.u_asserts.err_cnt == 0) begin
            $display("ALL CHECKS PASSED");
            $finish;
        end else begin
            stop_run("a protocol assertion on the cache failed");
        end
    end

endmodule

`default_nettype wire

// File: source/dcache_macros.svh
`ifndef DCACHE_MACROS_SVH
`define DCACHE_MACROS_SVH

// cache geometry, 64 sets of 64-byte lines
`define DC_INDEX_W   6
`define DC_OFFSET_W  6
`define DC_TAG_W     20
`define DC_LINE_W    512
`define DC_WAYS      2

// request size codes
`define DC_SIZE_BYTE 2'b00
`define DC_SIZE_HALF 2'b01
`define DC_SIZE_WORD 2'b10

`endif

// File: source/dcache_pkg.sv
`default_nettype none

`include "dcache_macros.svh"

package dcache_pkg;

    typedef logic [`DC_LINE_W-1:0] line_t;

    // pipeline request, strb only meaningful on stores
    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] wdata;    // lane aligned with strb
        logic [3:0]  strb;
        logic [1:0]  size;
        logic        write;
        logic        sign_ext;
    } dc_req_t;

    typedef struct packed {
        logic [31:0] rdata;
        logic        excp;     // misaligned access
    } dc_resp_t;

    typedef struct packed {
        logic                 valid;
        logic [`DC_TAG_W-1:0] tag;
    } tagv_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] addr;     // line aligned
    } mem_rreq_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] addr;
        line_t       data;
    } mem_wreq_t;

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        MISS,
        REFILL,
        WAIT_WRITE
    } ctrl_state_e;

endpackage

`default_nettype wire

// File: source/dcache_top.sv
`timescale 1ns/100ps
`default_nettype none

`include "dcache_macros.svh"

module dcache_top
    import dcache_pkg::*;
(
    input  wire           clk,
    input  wire           rstn,
    input  wire           i_req_valid,
    input  wire dc_req_t  i_req,
    output logic          o_ready,
    output dc_resp_t      o_resp,
    output mem_rreq_t     o_mem_rreq,
    input  wire           i_mem_rready,
    input  wire line_t    i_mem_rdata,
    output mem_wreq_t     o_mem_wreq,
    input  wire           i_mem_wready
);

    tagv_t [`DC_WAYS-1:0]      tag_rdata;
    line_t [`DC_WAYS-1:0]      line_rdata;
    logic [`DC_INDEX_W-1:0]    raddr;
    logic [`DC_INDEX_W-1:0]    index;
    logic [`DC_WAYS-1:0]       tag_we;
    logic [`DC_WAYS-1:0]       line_we;
    tagv_t                     tag_wdata;
    line_t                     line_wdata;
    logic                      victim_way;
    logic [`DC_WAYS-1:0]       dirty;
    logic [`DC_WAYS-1:0]       valid;
    logic                      lru_we, lru_way;
    logic                      dirty_we, dirty_way, dirty_val;
    logic                      valid_set;
    dc_req_t                   lane_req;
    line_t                     lane_line;
    logic [31:0]               lane_rdata;
    line_t                     store_line;
    logic                      misaligned;
    logic                      wb_start, wb_dirty, wb_done, wb_restart;
    line_t                     wb_line;
    logic [31:0]               wb_addr;

    for (genvar w = 0; w < `DC_WAYS; w++) begin : g_way
        way_ram #(.T(tagv_t)) u_tag_ram (
            .clk     (clk),
            .i_raddr (raddr),
            .i_waddr (index),
            .i_we    (tag_we[w]),
            .i_wdata (tag_wdata),
            .o_rdata (tag_rdata[w])
        );

        way_ram #(.T(line_t)) u_line_ram (
            .clk     (clk),
            .i_raddr (raddr),
            .i_waddr (index),
            .i_we    (line_we[w]),
            .i_wdata (line_wdata),
            .o_rdata (line_rdata[w])
        );
    end

    set_state u_set_state (
        .clk          (clk),
        .rstn         (rstn),
        .i_index      (index),
        .i_lru_we     (lru_we),
        .i_lru_way    (lru_way),
        .i_dirty_we   (dirty_we),
        .i_dirty_way  (dirty_way),
        .i_dirty_val  (dirty_val),
        .i_valid_set  (valid_set),
        .o_victim_way (victim_way),
        .o_dirty      (dirty),
        .o_valid      (valid)
    );

    lane_align u_lane_align (
        .i_req        (lane_req),
        .i_line       (lane_line),
        .o_rdata      (lane_rdata),
        .o_store_line (store_line),
        .o_misaligned (misaligned)
    );

    miss_ctrl u_miss_ctrl (
        .clk          (clk),
        .rstn         (rstn),
        .i_req_valid  (i_req_valid),
        .i_req        (i_req),
        .o_ready      (o_ready),
        .o_resp       (o_resp),
        .i_tag_rdata  (tag_rdata),
        .i_line_rdata (line_rdata),
        .o_raddr      (raddr),
        .o_index      (index),
        .o_tag_we     (tag_we),
        .o_tag_wdata  (tag_wdata),
        .o_line_we    (line_we),
        .o_line_wdata (line_wdata),
        .i_victim_way (victim_way),
        .i_dirty      (dirty),
        .i_valid      (valid),
        .o_lru_we     (lru_we),
        .o_lru_way    (lru_way),
        .o_dirty_we   (dirty_we),
        .o_dirty_way  (dirty_way),
        .o_dirty_val  (dirty_val),
        .o_valid_set  (valid_set),
        .o_lane_req   (lane_req),
        .o_lane_line  (lane_line),
        .i_lane_rdata (lane_rdata),
        .i_store_line (store_line),
        .i_misaligned (misaligned),
        .o_mem_rreq   (o_mem_rreq),
        .i_mem_rready (i_mem_rready),
        .i_mem_rdata  (i_mem_rdata),
        .o_wb_start   (wb_start),
        .o_wb_line    (wb_line),
        .o_wb_addr    (wb_addr),
        .o_wb_dirty   (wb_dirty),
        .i_wb_done    (wb_done),
        .o_wb_restart (wb_restart)
    );

    write_back u_write_back (
        .clk          (clk),
        .rstn         (rstn),
        .i_start      (wb_start),
        .i_dirty      (wb_dirty),
        .i_line       (wb_line),
        .i_addr       (wb_addr),
        .o_done       (wb_done),
        .i_restart    (wb_restart),
        .o_mem_wreq   (o_mem_wreq),
        .i_mem_wready (i_mem_wready)
    );

endmodule

`default_nettype wire

// File: source/lane_align.sv
`timescale 1ns/100ps
`default_nettype none

`include "dcache_macros.svh"

module lane_align
    import dcache_pkg::*;
(
    input  wire dc_req_t  i_req,
    input  wire line_t    i_line,
    output logic [31:0]   o_rdata,
    output line_t         o_store_line,
    output logic          o_misaligned
);

    logic [`DC_OFFSET_W-3:0] word_sel;
    logic [31:0]             word;
    logic [7:0]              ld_byte;
    logic [15:0]             ld_half;

    assign word_sel = i_req.addr[`DC_OFFSET_W-1:2];
    assign word     = i_line[word_sel*32 +: 32];
    assign ld_byte  = word[i_req.addr[1:0]*8 +: 8];
    assign ld_half  = word[i_req.addr[1]*16 +: 16];

    always_comb begin
        case (i_req.size)
            `DC_SIZE_BYTE: o_rdata = {{24{i_req.sign_ext & ld_byte[7]}}, ld_byte};
            `DC_SIZE_HALF: o_rdata = {{16{i_req.sign_ext & ld_half[15]}}, ld_half};
            default:       o_rdata = word;
        endcase
    end

    // loads pass the line through untouched
    always_comb begin
        o_store_line = i_line;
        if (i_req.write) begin
            for (int b = 0; b < 4; b++) begin
                if (i_req.strb[b]) begin
                    o_store_line[word_sel*32 + b*8 +: 8] = i_req.wdata[b*8 +: 8];
                end
            end
        end
    end

    always_comb begin
        case (i_req.size)
            `DC_SIZE_HALF: o_misaligned = i_req.addr[0];
            `DC_SIZE_WORD: o_misaligned = |i_req.addr[1:0];
            default:       o_misaligned = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

// File: source/miss_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

`include "dcache_macros.svh"

module miss_ctrl
    import dcache_pkg::*;
(
    input  wire                          clk,
    input  wire                          rstn,
    input  wire                          i_req_valid,
    input  wire dc_req_t                 i_req,
    output logic                         o_ready,
    output dc_resp_t                     o_resp,
    input  wire tagv_t [`DC_WAYS-1:0]    i_tag_rdata,
    input  wire line_t [`DC_WAYS-1:0]    i_line_rdata,
    output logic [`DC_INDEX_W-1:0]       o_raddr,
    output logic [`DC_INDEX_W-1:0]       o_index,
    output logic [`DC_WAYS-1:0]          o_tag_we,
    output tagv_t                        o_tag_wdata,
    output logic [`DC_WAYS-1:0]          o_line_we,
    output line_t                        o_line_wdata,
    input  wire                          i_victim_way,
    input  wire [`DC_WAYS-1:0]           i_dirty,
    input  wire [`DC_WAYS-1:0]           i_valid,
    output logic                         o_lru_we,
    output logic                         o_lru_way,
    output logic                         o_dirty_we,
    output logic                         o_dirty_way,
    output logic                         o_dirty_val,
    output logic                         o_valid_set,
    output dc_req_t                      o_lane_req,
    output line_t                        o_lane_line,
    input  wire [31:0]                   i_lane_rdata,
    input  wire line_t                   i_store_line,
    input  wire                          i_misaligned,
    output mem_rreq_t                    o_mem_rreq,
    input  wire                          i_mem_rready,
    input  wire line_t                   i_mem_rdata,
    output logic                         o_wb_start,
    output line_t                        o_wb_line,
    output logic [31:0]                  o_wb_addr,
    output logic                         o_wb_dirty,
    input  wire                          i_wb_done,
    output logic                         o_wb_restart
);

    ctrl_state_e           state_q, state_d;
    dc_req_t               req_q;
    line_t                 ret_q;      // refill line
    logic [`DC_TAG_W-1:0]  req_tag;
    logic [`DC_WAYS-1:0]   hit;
    logic                  hit_way;

    assign req_tag = req_q.addr[31 -: `DC_TAG_W];
    assign o_index = req_q.addr[`DC_OFFSET_W +: `DC_INDEX_W];
    assign o_raddr = i_req.addr[`DC_OFFSET_W +: `DC_INDEX_W];   // arrays read on the sampling edge

    always_comb begin
        for (int w = 0; w < `DC_WAYS; w++) begin
            hit[w] = i_valid[w] & i_tag_rdata[w].valid & (i_tag_rdata[w].tag == req_tag);
        end
    end
    assign hit_way = hit[1];

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == IDLE && i_req_valid) begin
            req_q <= i_req;
        end
        if (o_mem_rreq.valid && i_mem_rready) begin
            ret_q <= i_mem_rdata;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE:       if (i_req_valid) state_d = LOOKUP;
            LOOKUP:     state_d = (i_misaligned || |hit) ? IDLE : MISS;
            MISS:       if (i_mem_rready) state_d = REFILL;
            REFILL:     state_d = WAIT_WRITE;
            WAIT_WRITE: if (i_wb_done) state_d = IDLE;
            default:    state_d = IDLE;
        endcase
    end

    // datapath selects
    assign o_lane_req   = req_q;
    assign o_lane_line  = (state_q == LOOKUP) ? i_line_rdata[hit_way] : ret_q;
    assign o_line_wdata = i_store_line;
    assign o_tag_wdata  = '{valid: 1'b1, tag: req_tag};

    assign o_mem_rreq.valid = (state_q == MISS);
    assign o_mem_rreq.addr  = {req_q.addr[31:`DC_OFFSET_W], {`DC_OFFSET_W{1'b0}}};

    // victim captured by write_back on the start pulse
    assign o_wb_line  = i_line_rdata[i_victim_way];
    assign o_wb_addr  = {i_tag_rdata[i_victim_way].tag, o_index, {`DC_OFFSET_W{1'b0}}};
    assign o_wb_dirty = i_valid[i_victim_way] & i_dirty[i_victim_way];

    assign o_resp.excp  = i_misaligned;
    assign o_resp.rdata = (i_misaligned || req_q.write) ? 32'd0 : i_lane_rdata;

    always_comb begin
        o_ready      = 1'b0;
        o_tag_we     = '0;
        o_line_we    = '0;
        o_lru_we     = 1'b0;
        o_lru_way    = 1'b0;
        o_dirty_we   = 1'b0;
        o_dirty_way  = 1'b0;
        o_dirty_val  = 1'b0;
        o_valid_set  = 1'b0;
        o_wb_start   = 1'b0;
        o_wb_restart = 1'b0;
        case (state_q)
            LOOKUP: begin
                if (i_misaligned) begin
                    o_ready = 1'b1;        // exception, nothing written
                end else if (|hit) begin
                    o_ready   = 1'b1;
                    o_lru_we  = 1'b1;
                    o_lru_way = hit_way;
                    if (req_q.write) begin
                        o_line_we[hit_way] = 1'b1;
                        o_dirty_we         = 1'b1;
                        o_dirty_way        = hit_way;
                        o_dirty_val        = 1'b1;
                    end
                end else begin
                    o_wb_start = 1'b1;
                end
            end
            REFILL: begin
                o_tag_we[i_victim_way]  = 1'b1;
                o_line_we[i_victim_way] = 1'b1;
                o_lru_we                = 1'b1;
                o_lru_way               = i_victim_way;
                o_dirty_we              = 1'b1;
                o_dirty_way             = i_victim_way;
                o_dirty_val             = req_q.write;   // store miss leaves line dirty
                o_valid_set             = 1'b1;
            end
            WAIT_WRITE: begin
                o_ready      = i_wb_done;
                o_wb_restart = i_wb_done;
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// File: source/set_state.sv
`timescale 1ns/100ps
`default_nettype none

`include "dcache_macros.svh"

module set_state (
    input  wire                    clk,
    input  wire                    rstn,
    input  wire [`DC_INDEX_W-1:0]  i_index,
    input  wire                    i_lru_we,
    input  wire                    i_lru_way,
    input  wire                    i_dirty_we,
    input  wire                    i_dirty_way,
    input  wire                    i_dirty_val,
    input  wire                    i_valid_set,
    output logic                   o_victim_way,
    output logic [`DC_WAYS-1:0]    o_dirty,
    output logic [`DC_WAYS-1:0]    o_valid
);

    localparam int SETS = 1 << `DC_INDEX_W;

    logic [SETS-1:0]                  mru_q;    // most recently used way per set
    logic [SETS-1:0][`DC_WAYS-1:0]    dirty_q;
    logic [SETS-1:0][`DC_WAYS-1:0]    valid_q;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            mru_q   <= '0;
            dirty_q <= '0;
            valid_q <= '0;
        end else begin
            if (i_lru_we) begin
                mru_q[i_index] <= i_lru_way;
            end
            if (i_dirty_we) begin
                dirty_q[i_index][i_dirty_way] <= i_dirty_val;
            end
            // refill writes valid and dirty of the same way
            if (i_valid_set) begin
                valid_q[i_index][i_dirty_way] <= 1'b1;
            end
        end
    end

    assign o_dirty = dirty_q[i_index];
    assign o_valid = valid_q[i_index];

    // empty ways first, else the one not recently used
    assign o_victim_way = !o_valid[0] ? 1'b0 :
                          !o_valid[1] ? 1'b1 : ~mru_q[i_index];

endmodule

`default_nettype wire

// File: source/way_ram.sv
`timescale 1ns/100ps
`default_nettype none

`include "dcache_macros.svh"

// one read port, one write port, both synchronous
module way_ram #(
    parameter type T = logic
) (
    input  wire                    clk,
    input  wire [`DC_INDEX_W-1:0]  i_raddr,
    input  wire [`DC_INDEX_W-1:0]  i_waddr,
    input  wire                    i_we,
    input  wire T                  i_wdata,
    output T                       o_rdata
);

    localparam int DEPTH = 1 << `DC_INDEX_W;

    T mem [DEPTH];

    always_ff @(posedge clk) begin
        if (i_we) begin
            mem[i_waddr] <= i_wdata;
        end
        o_rdata <= mem[i_raddr];   // old data on same-address collision
    end

endmodule

`default_nettype wire

// File: source/write_back.sv
`timescale 1ns/100ps
`default_nettype none

module write_back
    import dcache_pkg::*;
(
    input  wire           clk,
    input  wire           rstn,
    input  wire           i_start,
    input  wire           i_dirty,
    input  wire line_t    i_line,
    input  wire [31:0]    i_addr,
    output logic          o_done,
    input  wire           i_restart,
    output mem_wreq_t     o_mem_wreq,
    input  wire           i_mem_wready
);

    typedef enum logic [1:0] {
        WB_INIT,
        WB_WRITE,
        WB_FINISH
    } wb_state_e;

    wb_state_e    state_q;
    line_t        line_q;
    logic [31:0]  addr_q;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state_q <= WB_INIT;
        end else begin
            case (state_q)
                WB_INIT:   if (i_start) state_q <= i_dirty ? WB_WRITE : WB_FINISH;
                WB_WRITE:  if (i_mem_wready) state_q <= WB_FINISH;
                WB_FINISH: if (i_restart) state_q <= WB_INIT;
                default:   state_q <= WB_INIT;
            endcase
        end
    end

    // victim copy, the arrays may be overwritten by the refill
    always_ff @(posedge clk) begin
        if (state_q == WB_INIT && i_start) begin
            line_q <= i_line;
            addr_q <= i_addr;
        end
    end

    assign o_mem_wreq.valid = (state_q == WB_WRITE);
    assign o_mem_wreq.addr  = addr_q;
    assign o_mem_wreq.data  = line_q;
    assign o_done           = (state_q == WB_FINISH);

endmodule

`default_nettype wire

// File: verilog.f
+incdir+source
source/dcache_pkg.sv
source/way_ram.sv
source/set_state.sv
source/lane_align.sv
source/miss_ctrl.sv
source/write_back.sv
source/dcache_top.sv
dv/dcache_assertions.sv
dv/dcache_tb.sv
